//--- common/core_bus_pkg.sv
package core_bus_pkg;

	localparam int bus_addr_w = 32;
	localparam int bus_data_w = 32;
	localparam int bus_sel_w  = bus_data_w / 8; // one bit per byte lane

	typedef logic [bus_addr_w-1:0] bus_addr_t;
	typedef logic [bus_data_w-1:0] bus_data_t;
	typedef logic [bus_sel_w-1:0]  bus_sel_t;

endpackage

//--- common/instr_stream_if.sv
`timescale 1ns/1ps

interface instr_stream_if;
	import core_bus_pkg::*;
	import rv_isa_pkg::*;

	logic      valid;
	logic      ready;
	bus_addr_t pc; // address of instr
	rv_instr_t instr;

	modport producer (
		output valid,
		output pc,
		output instr,
		input  ready
	);

	modport consumer (
		input  valid,
		input  pc,
		input  instr,
		output ready
	);

endinterface

//--- common/rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int xlen = 32;

	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_op     = 7'b0110011,
		op_system = 7'b1110011
	} opcode_e;

	// branch, load and store variants
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_bge = 3'b101;
	localparam logic [2:0] f3_lw  = 3'b010;
	localparam logic [2:0] f3_lbu = 3'b100;
	localparam logic [2:0] f3_sb  = 3'b000;
	localparam logic [2:0] f3_sh  = 3'b001;
	localparam logic [2:0] f3_sw  = 3'b010;

	// alu variants, shared by op and op-imm
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000; // srai
	localparam logic [11:0] ebreak_imm = 12'h001;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_type_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_e    opcode;
	} s_type_t;

	// b and j share the sign and imm[10:5] bits
	typedef struct packed {
		logic       sign;
		logic [5:0] imm_10_5;
		logic [3:0] j_4_1;
		logic       j_11;
		logic [7:0] j_19_12;
		logic [3:0] b_4_1;
		logic       b_11;
		opcode_e    opcode;
	} bj_type_t;

	typedef union packed {
		r_type_t  r;
		i_type_t  i;
		s_type_t  s;
		bj_type_t bj;
	} rv_instr_t;

endpackage

//--- dv/rv_core_vectors.mem
// per test: header {id, program words, preload words, stores}, program, preload,
// then expected stores as address, data, sel triples; a zero header ends the file
011a000c // alu_ops
12300093 ffa00113 fff0b193 0f00c213 0ff17293 00409313 40115393 00208433
006094b3 0020b533 0020c5b3 0020e633 0020f6b3 04102023 04302223 04402423
04502623 04602823 04702a23 04802c23 04902e23 06a02023 06b02223 06c02423
06d02623 00100073
00000040 00000123 0000000f 00000044 00000001 0000000f
00000048 000001d3 0000000f 0000004c 000000fa 0000000f
00000050 00001230 0000000f 00000054 fffffffd 0000000f
00000058 0000011d 0000000f 0000005c 01230000 0000000f
00000060 00000001 0000000f 00000064 fffffed9 0000000f
00000068 fffffffb 0000000f 0000006c 00000122 0000000f
020d0004 // upper_and_jumps, wrong path stores hit 0x7c
123450b7 00001117 00c001ef 06002e23 06002e23 01118267 06002e23 04102023
04202223 04302423 04402623 00100073 06002e23
00000040 12345000 0000000f 00000044 00001004 0000000f
00000048 0000000c 0000000f 0000004c 00000018 0000000f
03150004 // branches
00500093 ffd00113 00108463 06002e23 00208463 04102023 00209463 06002e23
00109463 04202223 0020d463 06002e23 00115463 04102423 0010d463 06002e23
00300193 fff18193 fe019ee3 04302623 00100073
00000040 00000005 0000000f 00000044 fffffffd 0000000f
00000048 00000005 0000000f 0000004c 00000000 0000000f
040a0205 // loads_and_stores
00002083 00404103 04102023 04202223 04101423 04100623 04000193 0041a203 0041a823 00100073
8badf00d 123456f0
00000040 8badf00d 0000000f 00000044 000000f0 0000000f
00000048 8badf00d 00000003 0000004c 8badf00d 00000001
00000050 000000f0 0000000f
05050001 // halt
00700093 04102023 00100073 04102223 04102423
00000040 00000007 0000000f
00000000

//--- dv/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;
	import core_bus_pkg::*;

	localparam int mem_words = 256;
	localparam int vec_words = 512;

	logic      clk;
	logic      arst_n = 1'b0;
	logic      ibus_cyc;
	logic      ibus_stb;
	bus_addr_t ibus_adr;
	bus_data_t ibus_dat_r = '0;
	logic      ibus_ack = 1'b0;
	logic      dbus_cyc;
	logic      dbus_stb;
	logic      dbus_we;
	bus_addr_t dbus_adr;
	bus_data_t dbus_dat_w;
	bus_sel_t  dbus_sel;
	bus_data_t dbus_dat_r = '0;
	logic      dbus_ack = 1'b0;
	logic      halted;

	logic [31:0] vec [vec_words];
	bus_data_t   imem [mem_words];
	bus_data_t   dmem [mem_words];
	bus_addr_t   got_adr [$]; // observed stores in bus order
	bus_data_t   got_dat [$];
	bus_sel_t    got_sel [$];
	logic        late_cycle = 1'b0;
	logic [1:0]  i_wait = 2'd0;
	logic [1:0]  d_wait = 2'd0;
	integer      seed = 32'h8747_910b;
	int          limit_cycles = 0;
	int          cur_id = 0;
	int          test_errs = 0;

	rv_core_top #(
		.reset_pc    (32'h0000_0000),
		.queue_depth (4)
	) uut (
		.clk        (clk),
		.arst_n     (arst_n),
		.ibus_cyc   (ibus_cyc),
		.ibus_stb   (ibus_stb),
		.ibus_adr   (ibus_adr),
		.ibus_dat_r (ibus_dat_r),
		.ibus_ack   (ibus_ack),
		.dbus_cyc   (dbus_cyc),
		.dbus_stb   (dbus_stb),
		.dbus_we    (dbus_we),
		.dbus_adr   (dbus_adr),
		.dbus_dat_w (dbus_dat_w),
		.dbus_sel   (dbus_sel),
		.dbus_dat_r (dbus_dat_r),
		.dbus_ack   (dbus_ack),
		.halted     (halted)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// one random draw per edge serves both slaves
	always @(posedge clk) begin : bus_slaves
		logic [31:0] rnd;
		int          b;
		rnd = $random(seed);
		ibus_ack <= 1'b0;
		dbus_ack <= 1'b0;
		if (!arst_n) begin
			i_wait <= rnd[1:0];
			d_wait <= rnd[3:2];
		end else begin
			if (ibus_cyc && ibus_stb && !ibus_ack) begin
				if (i_wait == 2'd0) begin
					assert (ibus_adr[1:0] == 2'b00) else begin
						$display("test %0d: instruction fetch from misaligned address %h",
							cur_id, ibus_adr);
						test_errs++;
					end
					ibus_ack <= 1'b1;
					ibus_dat_r <= imem[ibus_adr[9:2]];
					i_wait <= rnd[1:0]; // wait states of the next read
				end else begin
					i_wait <= i_wait - 2'd1;
				end
			end
			if (dbus_cyc && dbus_stb && !dbus_ack) begin
				if (d_wait == 2'd0) begin
					dbus_ack <= 1'b1;
					d_wait <= rnd[3:2];
					if (dbus_we) begin
						for (b = 0; b < 4; b++)
							if (dbus_sel[b])
								dmem[dbus_adr[9:2]][8*b +: 8] = dbus_dat_w[8*b +: 8];
					end else begin
						dbus_dat_r <= dmem[dbus_adr[9:2]];
					end
				end else begin
					d_wait <= d_wait - 2'd1;
				end
			end
		end
	end

	always @(posedge clk) begin
		if (arst_n && dbus_cyc && dbus_stb && dbus_we && dbus_ack) begin
			got_adr.push_back(dbus_adr);
			got_dat.push_back(dbus_dat_w);
			got_sel.push_back(dbus_sel);
		end
		if (halted && dbus_cyc)
			late_cycle = 1'b1;
	end

	function automatic string test_name(input int id);
		case (id)
			1: return "alu_ops";
			2: return "upper_and_jumps";
			3: return "branches";
			4: return "loads_and_stores";
			5: return "halt";
			default: return "unnamed";
		endcase
	endfunction

	task automatic compare_word(input string what, input bus_data_t expected,
		input bus_data_t actual);
		assert (actual === expected) else begin
			$display("Fail %s: expected %h, actual %h", what, expected, actual);
			test_errs++;
		end
	endtask

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout: test %0d never halted within %0d cycles", cur_id, limit_cycles);
		$display("Some tests failed");
		$finish;
	end

	initial begin : main
		int        p;
		int        k;
		int        id;
		int        n_prog;
		int        n_pre;
		int        n_st;
		int        total_words;
		int        passed;
		int        failed;
		bus_addr_t a;
		string     name;

		for (k = 0; k < vec_words; k++)
			vec[k] = '0;
		$readmemh("dv/rv_core_vectors.mem", vec);
		total_words = 0;
		p = 0;
		while (p < vec_words && vec[p] != 0) begin
			total_words += vec[p][23:16];
			p += 1 + vec[p][23:16] + vec[p][15:8] + 3 * vec[p][7:0];
		end
		limit_cycles = total_words * 200;

		p = 0;
		passed = 0;
		failed = 0;
		while (p < vec_words && vec[p] != 0) begin
			id = vec[p][31:24];
			n_prog = vec[p][23:16];
			n_pre = vec[p][15:8];
			n_st = vec[p][7:0];
			name = test_name(id);
			cur_id = id;
			test_errs = 0;
			@(posedge clk);
			arst_n <= 1'b0;
			@(posedge clk);
			for (k = 0; k < mem_words; k++) begin
				a = k * 4;
				imem[k] = {a[24:0], 7'h00}; // opcode zero retires as a no-op
				dmem[k] = a ^ 32'h5a5a_c3c3;
			end
			for (k = 0; k < n_prog; k++)
				imem[k] = vec[p + 1 + k];
			for (k = 0; k < n_pre; k++)
				dmem[k] = vec[p + 1 + n_prog + k];
			got_adr.delete();
			got_dat.delete();
			got_sel.delete();
			late_cycle = 1'b0;
			repeat (2) @(posedge clk);
			arst_n <= 1'b1;
			while (!halted) @(negedge clk);
			repeat (8) @(negedge clk); // window for traffic after halt

			p += 1 + n_prog + n_pre;
			for (k = 0; k < n_st; k++) begin
				assert (k < got_adr.size()) else begin
					$display("test %s: store %0d to %h never appeared on the data bus",
						name, k, vec[p]);
					test_errs++;
				end
				if (k < got_adr.size()) begin
					compare_word($sformatf("%s store %0d address", name, k),
						vec[p], got_adr[k]);
					compare_word($sformatf("%s store %0d data", name, k),
						vec[p + 1], got_dat[k]);
					compare_word($sformatf("%s store %0d sel", name, k),
						vec[p + 2], {28'd0, got_sel[k]});
				end
				p += 3;
			end
			assert (got_adr.size() <= n_st) else begin
				for (k = n_st; k < got_adr.size(); k++) begin
					$display("test %s: unexpected store to %h", name, got_adr[k]);
					test_errs++;
				end
			end
			assert (!late_cycle) else begin
				$display("test %s: a data bus cycle started after halt", name);
				test_errs++;
			end
			if (test_errs == 0) begin
				passed++;
				$display("test %0d %s: ok, %0d stores", id, name, n_st);
			end else begin
				failed++;
				$display("test %0d %s: %0d errors", id, name, test_errs);
			end
		end

		if (passed + failed == 0)
			$display("no tests found in the vector file");
		$display("tests passed %0d, failed %0d", passed, failed);
		if (failed == 0 && passed > 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- execute/exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
	input  logic                    clk,
	input  logic                    arst_n,
	instr_stream_if.consumer        in_s,
	output logic                    dbus_cyc,
	output logic                    dbus_stb,
	output logic                    dbus_we,
	output core_bus_pkg::bus_addr_t dbus_adr,
	output core_bus_pkg::bus_data_t dbus_dat_w,
	output core_bus_pkg::bus_sel_t  dbus_sel,
	input  core_bus_pkg::bus_data_t dbus_dat_r,
	input  logic                    dbus_ack,
	output logic                    redirect,
	output core_bus_pkg::bus_addr_t redirect_pc,
	output logic                    halted
);
	import rv_isa_pkg::*;
	import core_bus_pkg::*;

	typedef enum logic {st_issue, st_mem_wait} state_e;

	state_e          state;
	logic [xlen-1:0] regs [1:31]; // x0 reads as zero
	bus_data_t       src1;
	bus_data_t       src2;
	bus_data_t       val;
	bus_data_t       ld_data;
	bus_data_t       wb_data;
	bus_addr_t       jump_target;
	bus_addr_t       mem_addr;
	bus_sel_t        wmask;
	logic            jump_taken;
	logic            is_load;
	logic            is_store;
	logic            rd_write;
	logic            is_halt;
	logic            accept;
	logic            wb_en;
	logic [4:0]      wb_rd;
	logic [4:0]      ld_rd;
	logic            ld_pending;
	logic            ld_byte;

	assign src1 = (in_s.instr.r.rs1 == 5'd0) ? '0 : regs[in_s.instr.r.rs1];
	assign src2 = (in_s.instr.r.rs2 == 5'd0) ? '0 : regs[in_s.instr.r.rs2];

	exu u_exu (
		.instr       (in_s.instr),
		.pc          (in_s.pc),
		.src1        (src1),
		.src2        (src2),
		.val         (val),
		.jump_taken  (jump_taken),
		.jump_target (jump_target),
		.mem_addr    (mem_addr),
		.wmask       (wmask),
		.is_load     (is_load),
		.is_store    (is_store),
		.rd_write    (rd_write),
		.is_halt     (is_halt)
	);

	// hold off while a redirect flushes the wrong path
	assign in_s.ready = (state == st_issue) && !halted && !redirect;
	assign accept = in_s.valid && in_s.ready;
	assign ld_data = ld_byte ? {24'd0, dbus_dat_r[7:0]} : dbus_dat_r;

	always_comb begin
		wb_en = 1'b0;
		wb_rd = in_s.instr.r.rd;
		wb_data = val;
		if (state == st_mem_wait) begin
			wb_en = dbus_ack && ld_pending;
			wb_rd = ld_rd;
			wb_data = ld_data;
		end else if (accept && !is_load && !is_store) begin
			wb_en = rd_write;
		end
	end

	always_ff @(posedge clk) begin
		if (wb_en && wb_rd != 5'd0)
			regs[wb_rd] <= wb_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_issue;
			dbus_cyc <= 1'b0;
			dbus_stb <= 1'b0;
			dbus_we <= 1'b0;
			redirect <= 1'b0;
			halted <= 1'b0;
			ld_pending <= 1'b0;
		end else begin
			redirect <= 1'b0; // single-cycle pulse
			case (state)
				st_issue: begin
					if (accept && (is_load || is_store)) begin
						state <= st_mem_wait;
						dbus_cyc <= 1'b1;
						dbus_stb <= 1'b1;
						dbus_we <= is_store;
						ld_pending <= is_load;
					end else if (accept) begin
						redirect <= jump_taken;
						if (is_halt)
							halted <= 1'b1;
					end
				end
				st_mem_wait: begin
					if (dbus_ack) begin
						state <= st_issue;
						dbus_cyc <= 1'b0;
						dbus_stb <= 1'b0;
						dbus_we <= 1'b0;
						ld_pending <= 1'b0;
					end
				end
				default: state <= st_issue;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			redirect_pc <= jump_target;
			dbus_adr <= mem_addr;
			dbus_dat_w <= val; // store data, low lanes
			dbus_sel <= is_store ? wmask : '1;
			ld_rd <= in_s.instr.r.rd;
			ld_byte <= (in_s.instr.r.funct3 == f3_lbu);
		end
	end

endmodule

//--- execute/exu.sv
`timescale 1ns/1ps

module exu (
	input  rv_isa_pkg::rv_instr_t   instr,
	input  core_bus_pkg::bus_addr_t pc,
	input  core_bus_pkg::bus_data_t src1,
	input  core_bus_pkg::bus_data_t src2,
	output core_bus_pkg::bus_data_t val,
	output logic                    jump_taken,
	output core_bus_pkg::bus_addr_t jump_target,
	output core_bus_pkg::bus_addr_t mem_addr,
	output core_bus_pkg::bus_sel_t  wmask,
	output logic                    is_load,
	output logic                    is_store,
	output logic                    rd_write,
	output logic                    is_halt
);
	import rv_isa_pkg::*;
	import core_bus_pkg::*;

	bus_data_t  imm_i;
	bus_data_t  imm_s;
	bus_data_t  imm_b;
	bus_data_t  imm_j;
	bus_data_t  imm_u;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign funct3 = instr.r.funct3;
	assign funct7 = instr.r.funct7;

	assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
	assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
	assign imm_b = {{20{instr.bj.sign}}, instr.bj.b_11, instr.bj.imm_10_5,
		instr.bj.b_4_1, 1'b0};
	assign imm_j = {{12{instr.bj.sign}}, instr.bj.j_19_12, instr.bj.j_11,
		instr.bj.imm_10_5, instr.bj.j_4_1, 1'b0};
	assign imm_u = {instr.bj.sign, instr.bj.imm_10_5, instr.bj.j_4_1, instr.bj.j_11,
		instr.bj.j_19_12, 12'd0};

	assign mem_addr = src1 + ((instr.r.opcode == op_store) ? imm_s : imm_i);

	always_comb begin
		val = '0;
		jump_taken = 1'b0;
		jump_target = pc + imm_b;
		wmask = '0;
		is_load = 1'b0;
		is_store = 1'b0;
		rd_write = 1'b0;
		is_halt = 1'b0;
		case (instr.r.opcode)
			op_lui: begin
				val = imm_u;
				rd_write = 1'b1;
			end
			op_auipc: begin
				val = pc + imm_u;
				rd_write = 1'b1;
			end
			op_jal: begin
				val = pc + 32'd4; // link
				rd_write = 1'b1;
				jump_taken = 1'b1;
				jump_target = pc + imm_j;
			end
			op_jalr: begin
				val = pc + 32'd4;
				rd_write = 1'b1;
				jump_taken = 1'b1;
				jump_target = (src1 + imm_i) & ~32'd1;
			end
			op_branch: begin
				case (funct3)
					f3_beq: jump_taken = (src1 == src2);
					f3_bne: jump_taken = (src1 != src2);
					f3_bge: jump_taken = ($signed(src1) >= $signed(src2));
					default: jump_taken = 1'b0;
				endcase
			end
			op_load: begin
				is_load = (funct3 == f3_lw) || (funct3 == f3_lbu);
				rd_write = is_load; // data comes from the bus
			end
			op_store: begin
				val = src2;
				case (funct3)
					f3_sb: wmask = 4'h1;
					f3_sh: wmask = 4'h3;
					f3_sw: wmask = 4'hf;
					default: wmask = 4'h0;
				endcase
				is_store = (wmask != '0);
			end
			op_imm: begin
				rd_write = 1'b1;
				case (funct3)
					f3_add: val = src1 + imm_i;
					f3_sltu: val = bus_data_t'(src1 < imm_i);
					f3_xor: val = src1 ^ imm_i;
					f3_and: val = src1 & imm_i;
					f3_sll: val = src1 << instr.i.imm[4:0];
					f3_sr: begin
						val = $signed(src1) >>> instr.i.imm[4:0];
						rd_write = (funct7 == f7_alt); // srli not decoded
					end
					default: rd_write = 1'b0;
				endcase
			end
			op_op: begin
				rd_write = (funct7 == f7_base);
				case (funct3)
					f3_add: val = src1 + src2;
					f3_sll: val = src1 << src2[4:0];
					f3_sltu: val = bus_data_t'(src1 < src2);
					f3_xor: val = src1 ^ src2;
					f3_or: val = src1 | src2;
					f3_and: val = src1 & src2;
					default: rd_write = 1'b0;
				endcase
			end
			op_system: is_halt = (funct3 == 3'b000) && (instr.i.imm == ebreak_imm);
			default: val = '0; // retires as a no-op
		endcase
	end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter core_bus_pkg::bus_addr_t reset_pc = 32'h0000_0000
) (
	input  logic                    clk,
	input  logic                    arst_n,
	output logic                    ibus_cyc,
	output logic                    ibus_stb,
	output core_bus_pkg::bus_addr_t ibus_adr,
	input  core_bus_pkg::bus_data_t ibus_dat_r,
	input  logic                    ibus_ack,
	input  logic                    redirect,
	input  core_bus_pkg::bus_addr_t redirect_pc,
	instr_stream_if.producer        out_s
);
	import core_bus_pkg::*;

	bus_addr_t pc; // next fetch address
	logic      discard;
	logic      out_free;
	logic      launch;
	logic      keep_word;

	assign out_free = !out_s.valid || out_s.ready;
	assign launch = !ibus_cyc && out_free && !redirect;
	assign keep_word = ibus_cyc && ibus_ack && !discard && !redirect;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= reset_pc;
			ibus_cyc <= 1'b0;
			ibus_stb <= 1'b0;
			discard <= 1'b0;
			out_s.valid <= 1'b0;
		end else begin
			if (redirect)
				pc <= redirect_pc;
			else if (launch)
				pc <= pc + 32'd4;

			if (launch) begin
				ibus_cyc <= 1'b1;
				ibus_stb <= 1'b1;
			end else if (ibus_cyc && ibus_ack) begin
				ibus_cyc <= 1'b0;
				ibus_stb <= 1'b0;
			end

			// a redirect mid-read leaves a stale word in flight
			if (ibus_cyc && ibus_ack)
				discard <= 1'b0;
			else if (ibus_cyc && redirect)
				discard <= 1'b1;

			if (redirect)
				out_s.valid <= 1'b0; // wrong path
			else if (keep_word)
				out_s.valid <= 1'b1;
			else if (out_s.ready)
				out_s.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (launch)
			ibus_adr <= pc;
		if (keep_word) begin
			out_s.pc <= ibus_adr;
			out_s.instr <= ibus_dat_r;
		end
	end

endmodule

//--- rtl/instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
	parameter int queue_depth = 4
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             flush,
	instr_stream_if.consumer in_s,
	instr_stream_if.producer out_s
);
	import core_bus_pkg::*;
	import rv_isa_pkg::*;

	localparam int ptr_w = $clog2(queue_depth);

	bus_addr_t        pc_mem [queue_depth];
	rv_instr_t        instr_mem [queue_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0]   count;
	logic             push;
	logic             pop;

	assign in_s.ready = (count != (ptr_w + 1)'(queue_depth));
	assign out_s.valid = (count != '0);
	assign out_s.pc = pc_mem[rd_ptr];
	assign out_s.instr = instr_mem[rd_ptr];

	// nothing moves on a flush edge
	assign push = in_s.valid && in_s.ready && !flush;
	assign pop = out_s.valid && out_s.ready && !flush;

	always_ff @(posedge clk) begin
		if (push) begin
			pc_mem[wr_ptr] <= in_s.pc;
			instr_mem[wr_ptr] <= in_s.instr;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- rtl/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
	parameter core_bus_pkg::bus_addr_t reset_pc = 32'h0000_0000,
	parameter int queue_depth = 4
) (
	input  logic                    clk,
	input  logic                    arst_n,
	output logic                    ibus_cyc,
	output logic                    ibus_stb,
	output core_bus_pkg::bus_addr_t ibus_adr,
	input  core_bus_pkg::bus_data_t ibus_dat_r,
	input  logic                    ibus_ack,
	output logic                    dbus_cyc,
	output logic                    dbus_stb,
	output logic                    dbus_we,
	output core_bus_pkg::bus_addr_t dbus_adr,
	output core_bus_pkg::bus_data_t dbus_dat_w,
	output core_bus_pkg::bus_sel_t  dbus_sel,
	input  core_bus_pkg::bus_data_t dbus_dat_r,
	input  logic                    dbus_ack,
	output logic                    halted
);
	import core_bus_pkg::*;

	logic      redirect;
	bus_addr_t redirect_pc;

	instr_stream_if fetch_to_queue ();
	instr_stream_if queue_to_exec ();

	fetch_unit #(
		.reset_pc (reset_pc)
	) u_fetch (
		.clk         (clk),
		.arst_n      (arst_n),
		.ibus_cyc    (ibus_cyc),
		.ibus_stb    (ibus_stb),
		.ibus_adr    (ibus_adr),
		.ibus_dat_r  (ibus_dat_r),
		.ibus_ack    (ibus_ack),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.out_s       (fetch_to_queue.producer)
	);

	instr_queue #(
		.queue_depth (queue_depth)
	) u_queue (
		.clk    (clk),
		.arst_n (arst_n),
		.flush  (redirect), // wrong-path entries
		.in_s   (fetch_to_queue.consumer),
		.out_s  (queue_to_exec.producer)
	);

	exec_stage u_exec (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_s        (queue_to_exec.consumer),
		.dbus_cyc    (dbus_cyc),
		.dbus_stb    (dbus_stb),
		.dbus_we     (dbus_we),
		.dbus_adr    (dbus_adr),
		.dbus_dat_w  (dbus_dat_w),
		.dbus_sel    (dbus_sel),
		.dbus_dat_r  (dbus_dat_r),
		.dbus_ack    (dbus_ack),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.halted      (halted)
	);

endmodule

//--- vlog.f
common/core_bus_pkg.sv
common/rv_isa_pkg.sv
common/instr_stream_if.sv
rtl/fetch_unit.sv
rtl/instr_queue.sv
execute/exu.sv
execute/exec_stage.sv
rtl/rv_core_top.sv
dv/tb_rv_core.sv
